/* pwo_cfg.svh */
// Modulus, coefficient, lane, word, address and FIFO depth macros

`ifndef PWO_CFG_SVH
`define PWO_CFG_SVH

// ========================================
// Arithmetic
// ========================================

// Modulus q
`define PWO_Q 8380417

// Coefficient bits, each held in a lane one bit wider
`define PWO_COEF_W 23

// Coefficients per memory word
`define PWO_LANES 4

// ========================================
// Memory and buffering
// ========================================

`define PWO_WORD_W 96
`define PWO_ADDR_W 15
`define PWO_FIFO_DEPTH 4

`endif

/* pwo_pkg.sv */
// Operation enum and the operand-pair and result-write structs

`include "pwo_cfg.svh"

package pwo_pkg;

    // ========================================
    // Pointwise operation select
    // ========================================
    typedef enum logic [1:0] {
        OP_PWM = 2'd0,
        OP_PWA = 2'd1,
        OP_PWS = 2'd2
    } op_t;

    // ========================================
    // Payloads carried through the FIFOs
    // ========================================

    // One job for the arithmetic unit
    typedef struct packed {
        logic                   last;
        logic [`PWO_ADDR_W-1:0] c_addr;
        logic [`PWO_WORD_W-1:0] a_word;
        logic [`PWO_WORD_W-1:0] b_word;
    } operand_pair_t;

    // One write towards memory C
    typedef struct packed {
        logic                   last;
        logic [`PWO_ADDR_W-1:0] addr;
        logic [`PWO_WORD_W-1:0] data;
    } result_write_t;

endpackage

/* pwo_fifo.sv */
// Synchronous circular-buffer FIFO with a type-parameterized payload

`timescale 1ns/100ps

module pwo_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Head item, valid while not empty
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* pwo_operand_fetch.sv */
// Run sequencer and the two Wishbone read masters feeding the operand FIFO

`timescale 1ns/100ps
`include "pwo_cfg.svh"

module pwo_operand_fetch (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start_i,
    input  pwo_pkg::op_t             op_i,
    input  logic [`PWO_ADDR_W-1:0]   count_i,
    input  logic [`PWO_ADDR_W-1:0]   base_a_i,
    input  logic [`PWO_ADDR_W-1:0]   base_b_i,
    input  logic [`PWO_ADDR_W-1:0]   base_c_i,
    input  logic                     done_i,
    output logic                     busy_o,
    output pwo_pkg::op_t             op_o,
    // Read master A
    output logic                     a_cyc_o,
    output logic                     a_stb_o,
    output logic [`PWO_ADDR_W-1:0]   a_adr_o,
    input  logic [`PWO_WORD_W-1:0]   a_dat_i,
    input  logic                     a_ack_i,
    // Read master B
    output logic                     b_cyc_o,
    output logic                     b_stb_o,
    output logic [`PWO_ADDR_W-1:0]   b_adr_o,
    input  logic [`PWO_WORD_W-1:0]   b_dat_i,
    input  logic                     b_ack_i,
    // Operand FIFO
    output logic                     push_o,
    output pwo_pkg::operand_pair_t   pair_o,
    input  logic                     full_i
);

    logic                   busy_q;
    pwo_pkg::op_t           op_q;
    logic [`PWO_ADDR_W-1:0] count_q;
    logic [`PWO_ADDR_W-1:0] base_a_q;
    logic [`PWO_ADDR_W-1:0] base_b_q;
    logic [`PWO_ADDR_W-1:0] base_c_q;
    logic [`PWO_ADDR_W-1:0] idx_q;
    logic                   a_cyc_q;
    logic                   b_cyc_q;
    logic                   a_held_q;
    logic                   b_held_q;
    logic [`PWO_WORD_W-1:0] a_word_q;
    logic [`PWO_WORD_W-1:0] b_word_q;
    logic                   fetch_go;

    // New word only when both masters are idle and the FIFO has room
    assign fetch_go = busy_q & ~a_cyc_q & ~b_cyc_q & ~a_held_q & ~b_held_q
                    & (idx_q != count_q) & ~full_i;

    assign busy_o  = busy_q;
    assign op_o    = op_q;
    assign a_cyc_o = a_cyc_q;
    assign a_stb_o = a_cyc_q;
    assign b_cyc_o = b_cyc_q;
    assign b_stb_o = b_cyc_q;
    // idx_q only moves on a push, so addresses hold through each access
    assign a_adr_o = base_a_q + idx_q;
    assign b_adr_o = base_b_q + idx_q;

    assign push_o        = a_held_q & b_held_q;
    assign pair_o.last   = (idx_q == count_q - 1'b1);
    assign pair_o.c_addr = base_c_q + idx_q;
    assign pair_o.a_word = a_word_q;
    assign pair_o.b_word = b_word_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q   <= 1'b0;
            op_q     <= pwo_pkg::OP_PWM;
            count_q  <= '0;
            base_a_q <= '0;
            base_b_q <= '0;
            base_c_q <= '0;
            idx_q    <= '0;
            a_cyc_q  <= 1'b0;
            b_cyc_q  <= 1'b0;
            a_held_q <= 1'b0;
            b_held_q <= 1'b0;
        end else begin
            // Run control, start is ignored while busy
            if (!busy_q && start_i) begin
                busy_q   <= 1'b1;
                op_q     <= op_i;
                count_q  <= count_i;
                base_a_q <= base_a_i;
                base_b_q <= base_b_i;
                base_c_q <= base_c_i;
                idx_q    <= '0;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end

            if (fetch_go) begin
                a_cyc_q <= 1'b1;
                b_cyc_q <= 1'b1;
            end
            // Each read closes on its own ack
            if (a_cyc_q && a_ack_i) begin
                a_cyc_q  <= 1'b0;
                a_held_q <= 1'b1;
            end
            if (b_cyc_q && b_ack_i) begin
                b_cyc_q  <= 1'b0;
                b_held_q <= 1'b1;
            end
            if (push_o) begin
                a_held_q <= 1'b0;
                b_held_q <= 1'b0;
                idx_q    <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_cyc_q && a_ack_i) begin
            a_word_q <= a_dat_i;
        end
        if (b_cyc_q && b_ack_i) begin
            b_word_q <= b_dat_i;
        end
    end

endmodule

/* pwo_alu.sv */
// Two-stage modular arithmetic pipeline, result FIFO and Wishbone write master

`timescale 1ns/100ps
`include "pwo_cfg.svh"

module pwo_alu (
    input  logic                     clk,
    input  logic                     reset_n,
    input  pwo_pkg::op_t             op_i,
    input  pwo_pkg::operand_pair_t   pair_i,
    input  logic                     empty_i,
    output logic                     pop_o,
    // Write master C
    output logic                     c_cyc_o,
    output logic                     c_stb_o,
    output logic                     c_we_o,
    output logic [`PWO_ADDR_W-1:0]   c_adr_o,
    output logic [`PWO_WORD_W-1:0]   c_dat_o,
    input  logic                     c_ack_i,
    output logic                     done_o
);

    localparam int LANE_W = `PWO_COEF_W + 1;
    localparam int PROD_W = 2 * `PWO_COEF_W;
    localparam logic [PROD_W-1:0] Q_EXT = PROD_W'(`PWO_Q);

    logic [`PWO_COEF_W-1:0]  a_lane [`PWO_LANES];
    logic [`PWO_COEF_W-1:0]  b_lane [`PWO_LANES];
    logic [PROD_W-1:0]       s1_next [`PWO_LANES];
    logic [PROD_W-1:0]       s1_lane [`PWO_LANES];
    logic [PROD_W-1:0]       red_lane [`PWO_LANES];
    logic                    s1_valid;
    logic                    s1_last;
    logic [`PWO_ADDR_W-1:0]  s1_addr;
    pwo_pkg::op_t            s1_op;
    logic                    s2_valid;
    pwo_pkg::result_write_t  s2_next;
    pwo_pkg::result_write_t  s2_q;
    logic                    advance;
    logic                    res_full;
    logic                    res_empty;
    logic                    res_pop;
    pwo_pkg::result_write_t  res_head;
    logic                    c_cyc_q;
    logic                    done_q;

    // ========================================
    // Pipeline control
    // ========================================

    // Both stages hold while stage 2 cannot push
    assign advance = ~s2_valid | ~res_full;
    assign pop_o   = advance & ~empty_i;

    // Stage 1 raw lane results
    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            a_lane[i] = pair_i.a_word[i*LANE_W +: `PWO_COEF_W];
            b_lane[i] = pair_i.b_word[i*LANE_W +: `PWO_COEF_W];
            case (op_i)
                pwo_pkg::OP_PWM: s1_next[i] = PROD_W'(a_lane[i]) * PROD_W'(b_lane[i]);
                pwo_pkg::OP_PWA: s1_next[i] = PROD_W'(a_lane[i]) + PROD_W'(b_lane[i]);
                // a + q - b never goes negative
                default:         s1_next[i] = PROD_W'(a_lane[i]) + Q_EXT - PROD_W'(b_lane[i]);
            endcase
        end
    end

    // Stage 2 reduction, sums and differences are below 2q
    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            if (s1_op == pwo_pkg::OP_PWM) begin
                red_lane[i] = s1_lane[i] % Q_EXT;
            end else begin
                red_lane[i] = (s1_lane[i] >= Q_EXT) ? s1_lane[i] - Q_EXT : s1_lane[i];
            end
            s2_next.data[i*LANE_W +: LANE_W] = {1'b0, red_lane[i][`PWO_COEF_W-1:0]};
        end
        s2_next.last = s1_last;
        s2_next.addr = s1_addr;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= pop_o;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_lane <= s1_next;
            s1_last <= pair_i.last;
            s1_addr <= pair_i.c_addr;
            s1_op   <= op_i;
            s2_q    <= s2_next;
        end
    end

    pwo_fifo #(
        .payload_t (pwo_pkg::result_write_t),
        .DEPTH     (`PWO_FIFO_DEPTH)
    ) i_res_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .push_i  (s2_valid),
        .data_i  (s2_q),
        .pop_i   (res_pop),
        .data_o  (res_head),
        .full_o  (res_full),
        .empty_o (res_empty)
    );

    // ========================================
    // Wishbone write master
    // ========================================

    // Head stays put until its ack, so address and data hold steady
    assign res_pop = c_cyc_q & c_ack_i;
    assign c_cyc_o = c_cyc_q;
    assign c_stb_o = c_cyc_q;
    assign c_we_o  = c_cyc_q;
    assign c_adr_o = res_head.addr;
    assign c_dat_o = res_head.data;
    assign done_o  = done_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_cyc_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (!c_cyc_q && !res_empty) begin
                c_cyc_q <= 1'b1;
            end else if (c_cyc_q && c_ack_i) begin
                c_cyc_q <= 1'b0;
            end
            done_q <= res_pop & res_head.last;
        end
    end

endmodule

/* pwo_top.sv */
// Top level joining the operand fetcher, operand FIFO and arithmetic unit

`timescale 1ns/100ps
`include "pwo_cfg.svh"

module pwo_top (
    input  logic                     clk,
    input  logic                     reset_n,
    // Control
    input  logic                     start_i,
    input  pwo_pkg::op_t             op_i,
    input  logic [`PWO_ADDR_W-1:0]   count_i,
    input  logic [`PWO_ADDR_W-1:0]   base_a_i,
    input  logic [`PWO_ADDR_W-1:0]   base_b_i,
    input  logic [`PWO_ADDR_W-1:0]   base_c_i,
    output logic                     busy_o,
    output logic                     done_o,
    // Read master A
    output logic                     a_cyc_o,
    output logic                     a_stb_o,
    output logic [`PWO_ADDR_W-1:0]   a_adr_o,
    input  logic [`PWO_WORD_W-1:0]   a_dat_i,
    input  logic                     a_ack_i,
    // Read master B
    output logic                     b_cyc_o,
    output logic                     b_stb_o,
    output logic [`PWO_ADDR_W-1:0]   b_adr_o,
    input  logic [`PWO_WORD_W-1:0]   b_dat_i,
    input  logic                     b_ack_i,
    // Write master C
    output logic                     c_cyc_o,
    output logic                     c_stb_o,
    output logic                     c_we_o,
    output logic [`PWO_ADDR_W-1:0]   c_adr_o,
    output logic [`PWO_WORD_W-1:0]   c_dat_o,
    input  logic                     c_ack_i
);

    pwo_pkg::op_t           op_run;
    logic                   opnd_push;
    logic                   opnd_pop;
    logic                   opnd_full;
    logic                   opnd_empty;
    pwo_pkg::operand_pair_t opnd_in;
    pwo_pkg::operand_pair_t opnd_head;

    pwo_operand_fetch i_fetch (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start_i),
        .op_i     (op_i),
        .count_i  (count_i),
        .base_a_i (base_a_i),
        .base_b_i (base_b_i),
        .base_c_i (base_c_i),
        .done_i   (done_o),
        .busy_o   (busy_o),
        .op_o     (op_run),
        .a_cyc_o  (a_cyc_o),
        .a_stb_o  (a_stb_o),
        .a_adr_o  (a_adr_o),
        .a_dat_i  (a_dat_i),
        .a_ack_i  (a_ack_i),
        .b_cyc_o  (b_cyc_o),
        .b_stb_o  (b_stb_o),
        .b_adr_o  (b_adr_o),
        .b_dat_i  (b_dat_i),
        .b_ack_i  (b_ack_i),
        .push_o   (opnd_push),
        .pair_o   (opnd_in),
        .full_i   (opnd_full)
    );

    pwo_fifo #(
        .payload_t (pwo_pkg::operand_pair_t),
        .DEPTH     (`PWO_FIFO_DEPTH)
    ) i_opnd_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .push_i  (opnd_push),
        .data_i  (opnd_in),
        .pop_i   (opnd_pop),
        .data_o  (opnd_head),
        .full_o  (opnd_full),
        .empty_o (opnd_empty)
    );

    pwo_alu i_alu (
        .clk     (clk),
        .reset_n (reset_n),
        .op_i    (op_run),
        .pair_i  (opnd_head),
        .empty_i (opnd_empty),
        .pop_o   (opnd_pop),
        .c_cyc_o (c_cyc_o),
        .c_stb_o (c_stb_o),
        .c_we_o  (c_we_o),
        .c_adr_o (c_adr_o),
        .c_dat_o (c_dat_o),
        .c_ack_i (c_ack_i),
        .done_o  (done_o)
    );

endmodule

/* tb_clock_gen.sv */
// Testbench clock of 8 ns period and the power-on reset pulse

`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held low for the first 8 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

/* tb_pwo_top.sv */
// Testbench with Wishbone memory models, LFSR, run table, compare tasks and watchdog

`timescale 1ns/100ps
`include "pwo_cfg.svh"

module tb_pwo_top;

    localparam int     AW        = `PWO_ADDR_W;
    localparam int     WW        = `PWO_WORD_W;
    localparam int     CW        = `PWO_COEF_W;
    localparam int     LANE_W    = `PWO_COEF_W + 1;
    localparam longint Q         = `PWO_Q;
    localparam int     MEM_AW    = 10;
    localparam int     MEM_WORDS = 1 << MEM_AW;
    localparam int     NUM_ROWS  = 9;
    // Lane top bits set, so no valid result can look like it
    localparam logic [WW-1:0] MARKER = {8{12'hA5C}};

    typedef struct {
        pwo_pkg::op_t op;
        int           count;
        int           base_a;
        int           base_b;
        int           base_c;
        logic         expect_done;
        int           wr_extra;
    } row_t;

    logic                   clk;
    logic                   reset_n;
    logic                   start_i;
    pwo_pkg::op_t           op_i;
    logic [AW-1:0]          count_i;
    logic [AW-1:0]          base_a_i;
    logic [AW-1:0]          base_b_i;
    logic [AW-1:0]          base_c_i;
    logic                   busy_o;
    logic                   done_o;
    logic                   a_cyc_o;
    logic                   a_stb_o;
    logic [AW-1:0]          a_adr_o;
    logic [WW-1:0]          a_dat_i;
    logic                   a_ack_i;
    logic                   b_cyc_o;
    logic                   b_stb_o;
    logic [AW-1:0]          b_adr_o;
    logic [WW-1:0]          b_dat_i;
    logic                   b_ack_i;
    logic                   c_cyc_o;
    logic                   c_stb_o;
    logic                   c_we_o;
    logic [AW-1:0]          c_adr_o;
    logic [WW-1:0]          c_dat_o;
    logic                   c_ack_i;

    logic [WW-1:0]          mem_a [MEM_WORDS];
    logic [WW-1:0]          mem_b [MEM_WORDS];
    logic [WW-1:0]          mem_c [MEM_WORDS];
    logic [WW-1:0]          model_c [MEM_WORDS];
    logic [15:0]            lfsr_q = 16'd14945;
    int                     wr_extra;
    row_t                   rows [NUM_ROWS];

    tb_clock_gen i_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    pwo_top i_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start_i),
        .op_i     (op_i),
        .count_i  (count_i),
        .base_a_i (base_a_i),
        .base_b_i (base_b_i),
        .base_c_i (base_c_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .a_cyc_o  (a_cyc_o),
        .a_stb_o  (a_stb_o),
        .a_adr_o  (a_adr_o),
        .a_dat_i  (a_dat_i),
        .a_ack_i  (a_ack_i),
        .b_cyc_o  (b_cyc_o),
        .b_stb_o  (b_stb_o),
        .b_adr_o  (b_adr_o),
        .b_dat_i  (b_dat_i),
        .b_ack_i  (b_ack_i),
        .c_cyc_o  (c_cyc_o),
        .c_stb_o  (c_stb_o),
        .c_we_o   (c_we_o),
        .c_adr_o  (c_adr_o),
        .c_dat_o  (c_dat_o),
        .c_ack_i  (c_ack_i)
    );

    // ========================================
    // LFSR and reference arithmetic
    // ========================================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [CW-1:0] rand_coef();
        logic [31:0] v;
        v = take_bits(CW);
        if (v >= Q)
            v = v - Q;
        return v[CW-1:0];
    endfunction

    function automatic logic [WW-1:0] pack_lanes(input longint c0, c1, c2, c3);
        return {1'b0, CW'(c3), 1'b0, CW'(c2), 1'b0, CW'(c1), 1'b0, CW'(c0)};
    endfunction

    function automatic logic [WW-1:0] expect_word(input pwo_pkg::op_t op,
                                                  input logic [WW-1:0] aw,
                                                  input logic [WW-1:0] bw);
        logic [WW-1:0] w;
        longint        a;
        longint        b;
        longint        r;
        w = '0;
        for (int l = 0; l < `PWO_LANES; l++) begin
            a = aw[l*LANE_W +: CW];
            b = bw[l*LANE_W +: CW];
            case (op)
                pwo_pkg::OP_PWM: r = (a * b) % Q;
                pwo_pkg::OP_PWA: r = (a + b) % Q;
                default:         r = (a - b + Q) % Q;
            endcase
            w[l*LANE_W +: LANE_W] = {1'b0, CW'(r)};
        end
        return w;
    endfunction

    // ========================================
    // Checks
    // ========================================

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input pwo_pkg::result_write_t got,
                              input pwo_pkg::result_write_t want);
        if (got !== want) begin
            $display("** Error: mem_c[%h] = %h, expected %h", got.addr, got.data, want.data);
            report_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string name);
        if (got !== want) begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic scan_c();
        pwo_pkg::result_write_t got;
        pwo_pkg::result_write_t want;
        for (int a = 0; a < MEM_WORDS; a++) begin
            got.last  = 1'b0;
            got.addr  = AW'(a);
            got.data  = mem_c[a];
            want      = got;
            want.data = model_c[a];
            check_word(got, want);
        end
    endtask

    task automatic update_model(input row_t row);
        for (int i = 0; i < row.count; i++) begin
            model_c[row.base_c + i] = expect_word(row.op, mem_a[row.base_a + i],
                                                  mem_b[row.base_b + i]);
        end
    endtask

    task automatic drive_start(input row_t row);
        start_i  <= 1'b1;
        op_i     <= row.op;
        count_i  <= AW'(row.count);
        base_a_i <= AW'(row.base_a);
        base_b_i <= AW'(row.base_b);
        base_c_i <= AW'(row.base_c);
    endtask

    task automatic load_table();
        // op, count, base A, base B, base C, done expected, extra write wait
        rows[0] = '{pwo_pkg::OP_PWM,  8,   0,  64, 128, 1'b1, 0};
        rows[1] = '{pwo_pkg::OP_PWA,  6,  10,  80, 160, 1'b1, 0};
        rows[2] = '{pwo_pkg::OP_PWA,  2, 256, 258, 200, 1'b1, 0};
        rows[3] = '{pwo_pkg::OP_PWS,  2, 256, 258, 210, 1'b1, 0};
        rows[4] = '{pwo_pkg::OP_PWS,  8,  20,  90, 220, 1'b1, 0};
        // Start issued while row 4 is running
        rows[5] = '{pwo_pkg::OP_PWM,  4,   0,   0, 300, 1'b0, 0};
        // Slow write slave backs up both FIFOs
        rows[6] = '{pwo_pkg::OP_PWM, 32, 300, 400, 500, 1'b1, 12};
        rows[7] = '{pwo_pkg::OP_PWA, 16,  40, 120, 600, 1'b1, 0};
        rows[8] = '{pwo_pkg::OP_PWS, 16,  60, 140, 608, 1'b1, 0};
    endtask

    // ========================================
    // Wishbone slaves
    // ========================================

    initial begin : slaves
        int a_wait;
        int b_wait;
        int c_wait;
        a_wait  = -1;
        b_wait  = -1;
        c_wait  = -1;
        a_ack_i = 1'b0;
        b_ack_i = 1'b0;
        c_ack_i = 1'b0;
        a_dat_i = '0;
        b_dat_i = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int l = 0; l < `PWO_LANES; l++) begin
                mem_a[w][l*LANE_W +: LANE_W] = {1'b0, rand_coef()};
                mem_b[w][l*LANE_W +: LANE_W] = {1'b0, rand_coef()};
            end
            mem_c[w] = MARKER;
        end
        // Edge operands 0 and q-1 for both wrap directions
        mem_a[256] = pack_lanes(0, Q - 1, 0, Q - 1);
        mem_b[258] = pack_lanes(0, 0, Q - 1, Q - 1);
        mem_a[257] = pack_lanes(Q - 1, 1, 0, Q - 1);
        mem_b[259] = pack_lanes(1, Q - 1, Q - 1, 0);
        forever begin
            @(posedge clk);
            // A wait of -1 means no access in progress
            if (a_ack_i) begin
                a_ack_i <= 1'b0;
            end else if (a_cyc_o && a_stb_o) begin
                if (a_wait < 0)
                    a_wait = int'(take_bits(2));
                if (a_wait == 0) begin
                    a_ack_i <= 1'b1;
                    a_dat_i <= mem_a[a_adr_o[MEM_AW-1:0]];
                end
                a_wait = a_wait - 1;
            end
            if (b_ack_i) begin
                b_ack_i <= 1'b0;
            end else if (b_cyc_o && b_stb_o) begin
                if (b_wait < 0)
                    b_wait = int'(take_bits(2));
                if (b_wait == 0) begin
                    b_ack_i <= 1'b1;
                    b_dat_i <= mem_b[b_adr_o[MEM_AW-1:0]];
                end
                b_wait = b_wait - 1;
            end
            if (c_ack_i) begin
                c_ack_i <= 1'b0;
            end else if (c_cyc_o && c_stb_o && c_we_o) begin
                if (c_wait < 0)
                    c_wait = int'(take_bits(2)) + wr_extra;
                if (c_wait == 0) begin
                    c_ack_i <= 1'b1;
                    mem_c[c_adr_o[MEM_AW-1:0]] <= c_dat_o;
                end
                c_wait = c_wait - 1;
            end
        end
    end

    // ========================================
    // Run sequence
    // ========================================

    initial begin : main
        int   r;
        int   host;
        logic done_seen;
        start_i  = 1'b0;
        op_i     = pwo_pkg::OP_PWM;
        count_i  = '0;
        base_a_i = '0;
        base_b_i = '0;
        base_c_i = '0;
        wr_extra = 0;
        for (int a = 0; a < MEM_WORDS; a++)
            model_c[a] = MARKER;
        load_table();
        @(posedge reset_n);
        @(negedge clk);
        check_flag(a_cyc_o, 1'b0, "a_cyc_o");
        check_flag(a_stb_o, 1'b0, "a_stb_o");
        check_flag(b_cyc_o, 1'b0, "b_cyc_o");
        check_flag(b_stb_o, 1'b0, "b_stb_o");
        check_flag(c_cyc_o, 1'b0, "c_cyc_o");
        check_flag(c_stb_o, 1'b0, "c_stb_o");
        check_flag(c_we_o, 1'b0, "c_we_o");
        check_flag(busy_o, 1'b0, "busy_o");
        check_flag(done_o, 1'b0, "done_o");
        r = 0;
        while (r < NUM_ROWS) begin
            host     = r;
            wr_extra = rows[r].wr_extra;
            @(posedge clk);
            drive_start(rows[r]);
            @(posedge clk);
            start_i <= 1'b0;
            @(negedge clk);
            check_flag(busy_o, 1'b1, "busy_o");
            r++;
            // Next row pulses start mid-run and must be ignored
            if (r < NUM_ROWS && !rows[r].expect_done) begin
                repeat (2) @(posedge clk);
                drive_start(rows[r]);
                @(posedge clk);
                start_i <= 1'b0;
                r++;
            end
            done_seen = 1'b0;
            while (!done_seen) begin
                @(negedge clk);
                check_flag(busy_o, 1'b1, "busy_o");
                done_seen = done_o;
            end
            @(negedge clk);
            check_flag(busy_o, 1'b0, "busy_o");
            check_flag(done_o, 1'b0, "done_o");
            repeat (4) begin
                @(negedge clk);
                check_flag(done_o, 1'b0, "done_o");
            end
            update_model(rows[host]);
            scan_c();
        end
        $display("All tests passed");
        $finish;
    end

    // Limit grows with the total word count of the table
    initial begin : watchdog
        int total;
        int limit;
        total = 0;
        @(posedge reset_n);
        for (int k = 0; k < NUM_ROWS; k++)
            total += rows[k].count;
        limit = total * 20 + NUM_ROWS * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the runs did not finish within %0d cycles", limit);
        report_failure();
    end

endmodule

/* list.f */
+incdir+.
pwo_pkg.sv
pwo_fifo.sv
pwo_operand_fetch.sv
pwo_alu.sv
pwo_top.sv
tb_clock_gen.sv
tb_pwo_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the pointwise-operation testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_pwo_top -f list.f -o sim_pwo \
    > sim.log 2>&1 &&
./obj_dir/sim_pwo >> sim.log 2>&1 ||
echo "Build or simulation stopped early" >> sim.log
grep -q "Some tests failed" sim.log && echo "FAIL" && exit 1
grep -q "All tests passed" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
